//--- logic/decode_pkg.sv
/*
 * Shared definitions for the RV32I decode stage: widths, reset address,
 * major opcodes, operation enums, the classifier output struct and the
 * micro-op handed to execute.
 */

`default_nettype none

package decode_pkg;

    // ----------------------------------------------------------------------
    // Widths and addresses
    // ----------------------------------------------------------------------

    localparam int unsigned XLEN       = 32;         // Data and address width
    localparam int unsigned XL         = XLEN - 1;   // Top bit index
    localparam int unsigned REG_ADDR_W = 5;          // Register address width
    localparam int unsigned INSTR_W    = 32;         // Instruction width

    localparam logic [XL:0] PC_RESET_ADDR = 32'h1000_0000;  // First fetch
    localparam logic [XL:0] INSTR_BYTES   = 32'd4;          // Only 32-bit encodings

    // ----------------------------------------------------------------------
    // Major opcodes in bits 6:0
    // ----------------------------------------------------------------------

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // ----------------------------------------------------------------------
    // Operation encodings
    // ----------------------------------------------------------------------

    // The none value of every enum is zero, so an all-zero struct is a bubble
    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        CFU_NONE, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE,
        CFU_BLTU, CFU_BGEU, CFU_JAL, CFU_JALR
    } cfu_op_e;

    typedef enum logic [1:0] {
        LSU_NONE, LSU_LOAD, LSU_STORE
    } lsu_op_e;

    typedef enum logic [1:0] {
        LSU_BYTE, LSU_HALF, LSU_WORD
    } lsu_width_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_LSU, WB_NPC
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [1:0] {
        LHS_RS1, LHS_PC, LHS_ZERO
    } lhs_sel_e;

    // ----------------------------------------------------------------------
    // Structs
    // ----------------------------------------------------------------------

    // Classifier result, consumed by the operand builder and the top level
    typedef struct packed {
        alu_op_e                alu_op;
        cfu_op_e                cfu_op;
        lsu_op_e                lsu_op;
        lsu_width_e             lsu_width;
        logic                   lsu_sext;   // Sign extend loaded data
        wb_sel_e                wb_sel;
        imm_fmt_e               imm_fmt;
        lhs_sel_e               lhs_sel;
        logic                   rhs_imm;    // ALU rhs is the immediate
        logic [REG_ADDR_W-1:0]  rd;
        logic                   trap;       // Invalid encoding
    } class_t;

    // Micro-op handed to the execute stage
    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XL:0]            imm;
        logic [XL:0]            pc;
        logic [XL:0]            npc;
        logic [XL:0]            alu_lhs;
        logic [XL:0]            alu_rhs;
        alu_op_e                alu_op;
        cfu_op_e                cfu_op;
        lsu_op_e                lsu_op;
        lsu_width_e             lsu_width;
        logic                   lsu_sext;
        wb_sel_e                wb_sel;
        logic                   trap;
    } decode_uop_t;

endpackage

`default_nettype wire

//--- logic/op_classifier.sv
/*
 * RV32I instruction classifier. Maps opcode, funct3 and funct7 onto the
 * ALU, control-flow, load/store and writeback encodings, picks the
 * immediate format and operand sources, and flags invalid words.
 */

`default_nettype none

module op_classifier (
    input  logic [decode_pkg::INSTR_W-1:0]    instr_i,      // Instruction word
    output decode_pkg::class_t                class_o,      // Decoded fields
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,   // Source register 1
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o    // Source register 2
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;            // No RV32I encoding matched

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Source fields sit at fixed positions in every format
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // Common funct3 mapping of OP and OP-IMM, before funct7 refinement
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        bad               = 1'b0;
        class_o.alu_op    = ALU_NONE;
        class_o.cfu_op    = CFU_NONE;
        class_o.lsu_op    = LSU_NONE;
        class_o.lsu_width = LSU_BYTE;
        class_o.lsu_sext  = 1'b0;
        class_o.wb_sel    = WB_NONE;
        class_o.imm_fmt   = IMM_NONE;
        class_o.lhs_sel   = LHS_RS1;
        class_o.rhs_imm   = 1'b0;
        class_o.rd        = instr_i[11:7];
        class_o.trap      = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                class_o.alu_op   = ALU_ADD;                 // Address generation
                class_o.lsu_op   = LSU_LOAD;
                class_o.wb_sel   = WB_LSU;
                class_o.imm_fmt  = IMM_I;
                class_o.rhs_imm  = 1'b1;
                class_o.lsu_sext = !funct3[2];              // LBU and LHU clear it
                case (funct3)
                    3'b000, 3'b100: class_o.lsu_width = LSU_BYTE;
                    3'b001, 3'b101: class_o.lsu_width = LSU_HALF;
                    3'b010:         class_o.lsu_width = LSU_WORD;
                    default:        bad = 1'b1;
                endcase
            end
            OPC_STORE: begin
                class_o.alu_op  = ALU_ADD;
                class_o.lsu_op  = LSU_STORE;
                class_o.imm_fmt = IMM_S;
                class_o.rhs_imm = 1'b1;
                class_o.rd      = '0;                       // Bits 11:7 hold imm
                case (funct3)
                    3'b000:  class_o.lsu_width = LSU_BYTE;
                    3'b001:  class_o.lsu_width = LSU_HALF;
                    3'b010:  class_o.lsu_width = LSU_WORD;
                    default: bad = 1'b1;
                endcase
            end
            OPC_BRANCH: begin
                class_o.alu_op  = ALU_SUB;                  // rs1 - rs2 compare
                class_o.imm_fmt = IMM_B;
                class_o.rd      = '0;
                case (funct3)
                    3'b000:  class_o.cfu_op = CFU_BEQ;
                    3'b001:  class_o.cfu_op = CFU_BNE;
                    3'b100:  class_o.cfu_op = CFU_BLT;
                    3'b101:  class_o.cfu_op = CFU_BGE;
                    3'b110:  class_o.cfu_op = CFU_BLTU;
                    3'b111:  class_o.cfu_op = CFU_BGEU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                class_o.alu_op  = alu_from_funct3(funct3);
                class_o.wb_sel  = WB_ALU;
                class_o.imm_fmt = IMM_I;
                class_o.rhs_imm = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    class_o.imm_fmt = IMM_SHAMT;            // Shift-immediates
                    if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                        class_o.alu_op = ALU_SRA;
                    end else if (funct7 != 7'b0000000) begin
                        bad = 1'b1;
                    end
                end
            end
            OPC_OP: begin
                class_o.alu_op = alu_from_funct3(funct3);
                class_o.wb_sel = WB_ALU;
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    class_o.alu_op = ALU_SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    class_o.alu_op = ALU_SRA;
                end else if (funct7 != 7'b0000000) begin
                    bad = 1'b1;
                end
            end
            OPC_LUI: begin
                class_o.alu_op  = ALU_ADD;                  // 0 + imm
                class_o.wb_sel  = WB_ALU;
                class_o.imm_fmt = IMM_U;
                class_o.lhs_sel = LHS_ZERO;
                class_o.rhs_imm = 1'b1;
            end
            OPC_AUIPC: begin
                class_o.alu_op  = ALU_ADD;                  // pc + imm
                class_o.wb_sel  = WB_ALU;
                class_o.imm_fmt = IMM_U;
                class_o.lhs_sel = LHS_PC;
                class_o.rhs_imm = 1'b1;
            end
            OPC_JAL: begin
                class_o.cfu_op  = CFU_JAL;
                class_o.wb_sel  = WB_NPC;                   // Link address
                class_o.imm_fmt = IMM_J;
            end
            OPC_JALR: begin
                class_o.alu_op  = ALU_ADD;                  // Target rs1 + imm
                class_o.cfu_op  = CFU_JALR;
                class_o.wb_sel  = WB_NPC;
                class_o.imm_fmt = IMM_I;
                class_o.rhs_imm = 1'b1;
                bad             = (funct3 != 3'b000);
            end
            default: bad = 1'b1;                            // SYSTEM lands here too
        endcase

        // An invalid word leaves a bubble behind with only trap raised
        if (bad) begin
            class_o      = '0;
            class_o.trap = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_builder.sv
/*
 * Immediate extraction for the I, S, B, U, J and shift-amount formats,
 * and selection of the two ALU operands.
 */

`default_nettype none

module operand_builder (
    input  logic [decode_pkg::INSTR_W-1:0] instr_i,     // Instruction word
    input  decode_pkg::imm_fmt_e           imm_fmt_i,   // Immediate format
    input  decode_pkg::lhs_sel_e           lhs_sel_i,   // Left operand source
    input  logic                           rhs_imm_i,   // Right operand is imm
    input  logic [decode_pkg::XLEN-1:0]    pc_i,        // Current pc
    input  logic [decode_pkg::XLEN-1:0]    rs1_data_i,  // Forwarded rs1
    input  logic [decode_pkg::XLEN-1:0]    rs2_data_i,  // Forwarded rs2
    output logic [decode_pkg::XLEN-1:0]    imm_o,       // Extended immediate
    output logic [decode_pkg::XLEN-1:0]    alu_lhs_o,   // ALU left operand
    output logic [decode_pkg::XLEN-1:0]    alu_rhs_o    // ALU right operand
);

    import decode_pkg::*;

    logic sign;                 // Bit 31 is the sign in every format

    assign sign = instr_i[31];

    // ----------------------------------------------------------------------
    // Immediate
    // ----------------------------------------------------------------------

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: begin
                imm_o = {{(XLEN-13){sign}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {instr_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{(XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            IMM_SHAMT: imm_o = {{(XLEN-5){1'b0}}, instr_i[24:20]};  // Unsigned
            default:   imm_o = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // ALU operands
    // ----------------------------------------------------------------------

    always_comb begin
        case (lhs_sel_i)
            LHS_PC:   alu_lhs_o = pc_i;         // AUIPC
            LHS_ZERO: alu_lhs_o = '0;           // LUI
            default:  alu_lhs_o = rs1_data_i;
        endcase
    end

    assign alu_rhs_o = rhs_imm_i ? imm_o : rs2_data_i;

endmodule

`default_nettype wire

//--- logic/pc_tracker.sv
/*
 * Program counter register with reset address, redirect load and
 * advance on instruction consumption.
 */

`default_nettype none

module pc_tracker (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        eat_i,          // Instruction consumed
    input  logic                        cf_valid_i,     // Redirect strobe
    input  logic [decode_pkg::XLEN-1:0] cf_target_i,    // Redirect address
    output logic [decode_pkg::XLEN-1:0] pc_o,           // Current pc
    output logic [decode_pkg::XLEN-1:0] npc_o           // Sequential next pc
);

    import decode_pkg::*;

    logic [XL:0] pc_q;

    assign npc_o = pc_q + INSTR_BYTES;
    assign pc_o  = pc_q;

    // A redirect beats an eat in the same cycle
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (cf_valid_i) begin
            pc_q <= cf_target_i;
        end else if (eat_i) begin
            pc_q <= npc_o;
        end
    end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
/*
 * Decode and operand-gather stage top. Handshake with fetch and execute,
 * and assembly of the outgoing micro-op.
 */

`default_nettype none

module decode_stage (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  logic                              instr_valid_i,  // Fetch has a word
    input  logic [decode_pkg::INSTR_W-1:0]    instr_i,        // Word to decode
    input  logic                              ex_ready_i,     // Execute can accept
    input  logic                              cf_valid_i,     // Redirect strobe
    input  logic [decode_pkg::XLEN-1:0]       cf_target_i,    // Redirect address
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,     // Forwarded rs1
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,     // Forwarded rs2
    output logic                              instr_eat_o,    // Word consumed
    output logic                              ex_valid_o,     // Micro-op valid
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output decode_pkg::decode_uop_t           ex_uop_o
);

    import decode_pkg::*;

    class_t      cls;
    logic [XL:0] pc;
    logic [XL:0] npc;
    logic [XL:0] imm;
    logic [XL:0] alu_lhs;
    logic [XL:0] alu_rhs;

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------

    assign instr_eat_o = instr_valid_i && ex_ready_i;
    assign ex_valid_o  = instr_valid_i;

    // ----------------------------------------------------------------------
    // Submodules
    // ----------------------------------------------------------------------

    op_classifier u_classifier (
        .instr_i    (instr_i),
        .class_o    (cls),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o)
    );

    operand_builder u_operands (
        .instr_i    (instr_i),
        .imm_fmt_i  (cls.imm_fmt),
        .lhs_sel_i  (cls.lhs_sel),
        .rhs_imm_i  (cls.rhs_imm),
        .pc_i       (pc),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .imm_o      (imm),
        .alu_lhs_o  (alu_lhs),
        .alu_rhs_o  (alu_rhs)
    );

    pc_tracker u_pc (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .eat_i       (instr_eat_o),
        .cf_valid_i  (cf_valid_i),
        .cf_target_i (cf_target_i),
        .pc_o        (pc),
        .npc_o       (npc)
    );

    // ----------------------------------------------------------------------
    // Micro-op assembly
    // ----------------------------------------------------------------------

    always_comb begin
        ex_uop_o.rs1       = rs1_addr_o;
        ex_uop_o.rs2       = rs2_addr_o;
        ex_uop_o.rd        = cls.rd;          // Already zero for S, B and traps
        ex_uop_o.imm       = imm;
        ex_uop_o.pc        = pc;
        ex_uop_o.npc       = npc;
        ex_uop_o.alu_lhs   = alu_lhs;
        ex_uop_o.alu_rhs   = alu_rhs;
        ex_uop_o.alu_op    = cls.alu_op;
        ex_uop_o.cfu_op    = cls.cfu_op;
        ex_uop_o.lsu_op    = cls.lsu_op;
        ex_uop_o.lsu_width = cls.lsu_width;
        ex_uop_o.lsu_sext  = cls.lsu_sext;
        ex_uop_o.wb_sel    = cls.wb_sel;
        ex_uop_o.trap      = cls.trap;
    end

endmodule

`default_nettype wire

//--- tb/decode_model.svh
/*
 * Reference model for the decode stage testbench. Xorshift generator,
 * random RV32I instruction builder and the expected micro-op.
 */

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Valid RV32I word with random fields, or a fully random word one time in eight
function automatic logic [31:0] build_instr(input logic [31:0] pick, input logic [31:0] fields);
    logic [31:0] w;
    logic [2:0]  f3;
    int          sel;
    f3  = fields[14:12];
    sel = int'(pick[15:8]) % 9;
    if (pick[2:0] == 3'b000) begin
        return fields;
    end
    case (sel)
        0: begin
            f3 = pick[18:16] % 3'd5;                        // LB LH LW LBU LHU
            if (f3 > 3'd2) begin
                f3 = f3 + 3'd1;
            end
            w = {fields[31:15], f3, fields[11:7], OPC_LOAD};
        end
        1: w = {fields[31:15], 1'b0, pick[17:16] % 2'd3, fields[11:7], OPC_STORE};
        2: begin
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;                               // Skip the two holes
            end
            w = {fields[31:15], f3, fields[11:7], OPC_BRANCH};
        end
        3: begin
            w = {fields[31:7], OPC_OP_IMM};
            if (f3 == 3'd1) begin
                w[31:25] = 7'h00;
            end else if (f3 == 3'd5) begin
                w[31:25] = {1'b0, pick[16], 5'b0};          // SRLI or SRAI
            end
        end
        4: begin
            w = {fields[31:7], OPC_OP};
            w[31:25] = (pick[16] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        end
        5: w = {fields[31:7], OPC_LUI};
        6: w = {fields[31:7], OPC_AUIPC};
        7: w = {fields[31:7], OPC_JAL};
        default: w = {fields[31:15], 3'b000, fields[11:7], OPC_JALR};
    endcase
    return w;
endfunction

function automatic alu_op_e model_alu(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0: return alt ? ALU_SUB : ALU_ADD;
        3'd1: return ALU_SLL;
        3'd2: return ALU_SLT;
        3'd3: return ALU_SLTU;
        3'd4: return ALU_XOR;
        3'd5: return alt ? ALU_SRA : ALU_SRL;
        3'd6: return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// Expected micro-op for word w at the given pc and register values
function automatic decode_uop_t model_uop(input logic [31:0] w, input logic [31:0] pc,
                                          input logic [31:0] rs1_val,
                                          input logic [31:0] rs2_val);
    decode_uop_t u;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic        ok;
    f3        = w[14:12];
    f7        = w[31:25];
    imm_i     = {{20{w[31]}}, w[31:20]};
    ok        = 1'b1;
    u         = '0;
    u.rs1     = w[19:15];
    u.rs2     = w[24:20];
    u.rd      = w[11:7];
    u.pc      = pc;
    u.npc     = pc + 32'd4;
    u.alu_lhs = rs1_val;
    u.alu_rhs = rs2_val;
    case (w[6:0])
        OPC_LOAD: begin
            ok          = (f3[1:0] != 2'b11) && !(f3[2] && f3[1]);
            u.imm       = imm_i;
            u.alu_rhs   = imm_i;
            u.alu_op    = ALU_ADD;
            u.lsu_op    = LSU_LOAD;
            u.lsu_width = lsu_width_e'(f3[1:0]);            // funct3 low bits give size
            u.lsu_sext  = !f3[2];
            u.wb_sel    = WB_LSU;
        end
        OPC_STORE: begin
            ok          = (f3 < 3'd3);
            u.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
            u.alu_rhs   = u.imm;
            u.alu_op    = ALU_ADD;
            u.lsu_op    = LSU_STORE;
            u.lsu_width = lsu_width_e'(f3[1:0]);
            u.rd        = '0;
        end
        OPC_BRANCH: begin
            ok       = (f3[2:1] != 2'b01);
            u.imm    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            u.alu_op = ALU_SUB;
            u.rd     = '0;
            case (f3)
                3'd0:    u.cfu_op = CFU_BEQ;
                3'd1:    u.cfu_op = CFU_BNE;
                3'd4:    u.cfu_op = CFU_BLT;
                3'd5:    u.cfu_op = CFU_BGE;
                3'd6:    u.cfu_op = CFU_BLTU;
                default: u.cfu_op = CFU_BGEU;
            endcase
        end
        OPC_OP_IMM: begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                ok    = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
                u.imm = {27'd0, w[24:20]};                  // Shift amount
            end else begin
                u.imm = imm_i;
            end
            u.alu_op  = model_alu(f3, f3 == 3'd5 && f7[5]);
            u.alu_rhs = u.imm;
            u.wb_sel  = WB_ALU;
        end
        OPC_OP: begin
            ok       = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            u.alu_op = model_alu(f3, f7[5]);
            u.wb_sel = WB_ALU;
        end
        OPC_LUI, OPC_AUIPC: begin
            u.imm     = {w[31:12], 12'd0};
            u.alu_op  = ALU_ADD;
            u.alu_lhs = (w[6:0] == OPC_LUI) ? 32'd0 : pc;
            u.alu_rhs = u.imm;
            u.wb_sel  = WB_ALU;
        end
        OPC_JAL: begin
            u.imm    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            u.cfu_op = CFU_JAL;
            u.wb_sel = WB_NPC;
        end
        OPC_JALR: begin
            ok        = (f3 == 3'd0);
            u.imm     = imm_i;
            u.alu_rhs = imm_i;
            u.alu_op  = ALU_ADD;
            u.cfu_op  = CFU_JALR;
            u.wb_sel  = WB_NPC;
        end
        default: ok = 1'b0;
    endcase
    // Invalid words become a bubble with trap set
    if (!ok) begin
        u.rd        = '0;
        u.imm       = '0;
        u.alu_lhs   = rs1_val;
        u.alu_rhs   = rs2_val;
        u.alu_op    = ALU_NONE;
        u.cfu_op    = CFU_NONE;
        u.lsu_op    = LSU_NONE;
        u.lsu_width = LSU_BYTE;
        u.lsu_sext  = 1'b0;
        u.wb_sel    = WB_NONE;
        u.trap      = 1'b1;
    end
    return u;
endfunction

`endif

//--- tb/tb_decode_stage.sv
/*
 * Testbench for the decode stage. Clock and reset, random instruction
 * stimulus, field checks against the reference model and a summary.
 */

`default_nettype none

module tb_decode_stage;

    import decode_pkg::*;

    localparam int HALF_PERIOD   = 10;
    localparam int RESET_CYCLES  = 4;
    localparam int RESET_TIMEOUT = 8;
    localparam int NUM_EATS      = 3000;        // Instructions to consume
    localparam int MAX_CYCLES    = 30000;       // Limit of the stimulus loop

    `include "decode_model.svh"

    logic                  g_clk = 1'b0;
    logic                  g_resetn;
    logic                  instr_valid_i;
    logic [INSTR_W-1:0]    instr_i;
    logic                  ex_ready_i;
    logic                  cf_valid_i;
    logic [XL:0]           cf_target_i;
    logic [XL:0]           rs1_data_i;
    logic [XL:0]           rs2_data_i;
    logic                  instr_eat_o;
    logic                  ex_valid_o;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    decode_uop_t           ex_uop_o;

    logic [31:0] rng;
    logic [XL:0] exp_pc;                        // Model pc
    int          value_errors = 0;
    int          timeout_errors = 0;
    int          eat_count = 0;
    int          trap_count = 0;

    always #HALF_PERIOD g_clk = ~g_clk;

    decode_stage UUT (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .ex_ready_i    (ex_ready_i),
        .cf_valid_i    (cf_valid_i),
        .cf_target_i   (cf_target_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .instr_eat_o   (instr_eat_o),
        .ex_valid_o    (ex_valid_o),
        .rs1_addr_o    (rs1_addr_o),
        .rs2_addr_o    (rs2_addr_o),
        .ex_uop_o      (ex_uop_o)
    );

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
            value_errors++;
        end
    endtask

    task automatic check_outputs;
        decode_uop_t want;
        want = model_uop(instr_i, exp_pc, rs1_data_i, rs2_data_i);
        if (want.trap) begin
            trap_count++;
        end
        check_value("instr_eat_o", 32'(instr_eat_o), 32'(instr_valid_i && ex_ready_i));
        check_value("ex_valid_o", 32'(ex_valid_o), 32'(instr_valid_i));
        check_value("rs1_addr_o", 32'(rs1_addr_o), 32'(want.rs1));
        check_value("rs2_addr_o", 32'(rs2_addr_o), 32'(want.rs2));
        check_value("ex_uop_o.rs1", 32'(ex_uop_o.rs1), 32'(want.rs1));
        check_value("ex_uop_o.rs2", 32'(ex_uop_o.rs2), 32'(want.rs2));
        check_value("ex_uop_o.rd", 32'(ex_uop_o.rd), 32'(want.rd));
        check_value("ex_uop_o.imm", ex_uop_o.imm, want.imm);
        check_value("ex_uop_o.pc", ex_uop_o.pc, want.pc);
        check_value("ex_uop_o.npc", ex_uop_o.npc, want.npc);
        check_value("ex_uop_o.alu_lhs", ex_uop_o.alu_lhs, want.alu_lhs);
        check_value("ex_uop_o.alu_rhs", ex_uop_o.alu_rhs, want.alu_rhs);
        check_value("ex_uop_o.alu_op", 32'(ex_uop_o.alu_op), 32'(want.alu_op));
        check_value("ex_uop_o.cfu_op", 32'(ex_uop_o.cfu_op), 32'(want.cfu_op));
        check_value("ex_uop_o.lsu_op", 32'(ex_uop_o.lsu_op), 32'(want.lsu_op));
        check_value("ex_uop_o.lsu_width", 32'(ex_uop_o.lsu_width), 32'(want.lsu_width));
        check_value("ex_uop_o.lsu_sext", 32'(ex_uop_o.lsu_sext), 32'(want.lsu_sext));
        check_value("ex_uop_o.wb_sel", 32'(ex_uop_o.wb_sel), 32'(want.wb_sel));
        check_value("ex_uop_o.trap", 32'(ex_uop_o.trap), 32'(want.trap));
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    // Fetch keeps a word that was not eaten
    task automatic drive_inputs(input logic hold);
        logic [31:0] r_ctl;
        logic [31:0] r_pick;
        logic [31:0] r_fields;
        rng      = xorshift32(rng);
        r_ctl    = rng;
        rng      = xorshift32(rng);
        r_pick   = rng;
        rng      = xorshift32(rng);
        r_fields = rng;
        if (!hold) begin
            instr_valid_i <= (r_ctl[1:0] != 2'b00);
            instr_i       <= build_instr(r_pick, r_fields);
        end
        ex_ready_i  <= (r_ctl[3:2] != 2'b00);
        cf_valid_i  <= ((r_ctl[15:8] % 8'd10) == 8'd0);   // About one cycle in ten
        cf_target_i <= {r_pick[31:20], r_fields[19:2], 2'b00};
        rng         = xorshift32(rng);
        rs1_data_i  <= rng;
        rng         = xorshift32(rng);
        rs2_data_i  <= rng;
    endtask

    // A redirect wins over an eat in the same cycle
    task automatic advance_model;
        if (instr_valid_i && ex_ready_i) begin
            eat_count++;
        end
        if (cf_valid_i) begin
            exp_pc = cf_target_i;
        end else if (instr_valid_i && ex_ready_i) begin
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic wait_reset_state;
        int   waited;
        logic found;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < RESET_TIMEOUT) begin
            @(negedge g_clk);
            found = (ex_uop_o.pc === PC_RESET_ADDR);
            waited++;
        end
        if (!found) begin
            $display("Timeout: pc did not reach the reset address after reset");
            timeout_errors++;
        end else begin
            check_value("ex_uop_o.npc", ex_uop_o.npc, PC_RESET_ADDR + 32'd4);
            check_value("instr_eat_o", 32'(instr_eat_o), 32'd0);
            check_value("ex_valid_o", 32'(ex_valid_o), 32'd0);
        end
    endtask

    task automatic run_random;
        int   cycles;
        logic held;
        cycles = 0;
        held   = 1'b0;
        while (eat_count < NUM_EATS && cycles < MAX_CYCLES) begin
            @(posedge g_clk);
            drive_inputs(held);
            @(negedge g_clk);
            check_outputs();
            held = instr_valid_i && !ex_ready_i;
            advance_model();
            cycles++;
        end
        if (eat_count < NUM_EATS) begin
            $display("Timeout: only %0d of %0d instructions eaten in %0d cycles",
                     eat_count, NUM_EATS, cycles);
            timeout_errors++;
        end
    endtask

    initial begin
        g_resetn      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        ex_ready_i    = 1'b0;
        cf_valid_i    = 1'b0;
        cf_target_i   = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        rng           = 32'd8;
        exp_pc        = PC_RESET_ADDR;
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        wait_reset_state();
        if (timeout_errors == 0) begin
            run_random();
        end
        $display("Summary: %0d eats, %0d traps, %0d value errors, %0d timeouts",
                 eat_count, trap_count, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tb
logic/decode_pkg.sv
logic/op_classifier.sv
logic/operand_builder.sv
logic/pc_tracker.sv
logic/decode_stage.sv
tb/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_decode_stage -f sources.f \
        -Mdir obj_dir -o tb_decode_stage \
    && ./obj_dir/tb_decode_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
